// File: include/scrub_config.svh
// Scrub configuration constants: scrub range, burst shape, reset pipe and ID words
`ifndef SCRUB_CONFIG_SVH
`define SCRUB_CONFIG_SVH

// ---------------------------------------------------------------------------
// Scrub range and burst shape
// ---------------------------------------------------------------------------

// Last byte address scrubbed per channel, reduced to 8 KiB
// A full 16 GiB build overrides the scrubber parameter with 64'h3_FFFF_FFFF
`define SCRB_MAX_ADDR            64'h0000_0000_0000_1FFF

// Beats per burst minus one, each beat is 64 bytes so a burst covers 1 KiB
`define SCRB_BURST_LEN_MINUS1    15
`define SCRB_BEAT_BYTES          64

// Number of DDR channels with a scrubber
`define NUM_DDR                  4

// Depth of the raw reset filter ahead of the release flops
`define RST_PIPE_STAGES          4

// Fixed PCI ID words shown on id0/id1 when debug readback is off
`define CL_SH_ID0                32'hF001_1D0F
`define CL_SH_ID1                32'h1D51_FEDC

`endif

// File: src/scrub_pkg.sv
// Shared types for the DRAM scrub control path: addresses, ID words, selects, FSM states
`default_nettype none

package scrub_pkg;

   // Byte address into one DDR channel
   typedef logic [63:0] ddr_addr_t;

   // One 32-bit identification word
   typedef logic [31:0] id_word_t;

   // Debug readback channel select, note D sits before C
   // Values 4 to 7 are not listed and read channel A
   typedef enum logic [2:0]
   {
      SEL_DDRA = 3'd0,
      SEL_DDRB = 3'd1,
      SEL_DDRD = 3'd2,
      SEL_DDRC = 3'd3
   } ddr_sel_t;

   // Scrubber FSM
   typedef enum logic [1:0]
   {
      SCRB_IDLE,
      SCRB_RUN,
      SCRB_DONE
   } scrub_state_t;

endpackage

`default_nettype wire

// File: src/reset_sync.sv
// Reset synchronizer: filters the raw reset and releases sync_rst_n cleanly on clk
`timescale 1ns/1ps
`default_nettype none

`include "scrub_config.svh"

module reset_sync
#(
   parameter int unsigned STAGES = `RST_PIPE_STAGES
)
(
   input  wire  clk,
   input  wire  rst_main_n,
   output logic sync_rst_n
);

   logic [STAGES-1:0] pipe_q;
   logic              pre_sync_rst_n;

   // Filter chain, cleared at once when the raw reset falls
   always_ff @(posedge clk or negedge rst_main_n)
   begin
      if (!rst_main_n)
      begin
         pipe_q <= '0;
      end
      else
      begin
         pipe_q[0] <= 1'b1;
         for (int i = 1; i < STAGES; i++)
         begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   // Two release flops behind the filter
   always_ff @(posedge clk or negedge pipe_q[STAGES-1])
   begin
      if (!pipe_q[STAGES-1])
      begin
         pre_sync_rst_n <= 1'b0;
         sync_rst_n     <= 1'b0;
      end
      else
      begin
         pre_sync_rst_n <= 1'b1;
         sync_rst_n     <= pre_sync_rst_n;
      end
   end

endmodule

`default_nettype wire

// File: src/flr_responder.sv
// Function-level reset responder: answers a registered FLR request with a done pulse
`timescale 1ns/1ps
`default_nettype none

module flr_responder
(
   input  wire  clk,
   input  wire  sync_rst_n,
   input  wire  flr_assert,
   output logic flr_done
);

   logic flr_assert_q;

   // Request is sampled first, the pulse follows one edge later
   // A held request toggles done, so pulses never come back to back
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule

`default_nettype wire

// File: src/scrub_ctl_regs.sv
// Scrub control register: holds the shell control word and decodes enables and debug select
`timescale 1ns/1ps
`default_nettype none

`include "scrub_config.svh"

module scrub_ctl_regs
(
   input  wire                     clk,
   input  wire                     sync_rst_n,
   input  wire  [31:0]             ctl0,
   output logic [`NUM_DDR-1:0]     scrb_en,
   output logic                    dbg_en,
   output scrub_pkg::ddr_sel_t     dbg_sel
);

   logic [31:0] ctl0_q;

   // ---------------------------------------------------------------------------
   // Control word capture
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl0_q <= 32'd0;
      end
      else
      begin
         ctl0_q <= ctl0;
      end
   end

   // ---------------------------------------------------------------------------
   // Field decode
   //   bit 31     debug readback enable
   //   bits 30:28 debug channel select
   //   bit 3      DDR C enable
   //   bit 2      DDR D enable
   //   bit 1      DDR B enable
   //   bit 0      DDR A enable
   // ---------------------------------------------------------------------------

   // Enables leave in channel order A,B,C,D, so C and D swap here
   assign scrb_en[0] = ctl0_q[0];
   assign scrb_en[1] = ctl0_q[1];
   assign scrb_en[2] = ctl0_q[3];
   assign scrb_en[3] = ctl0_q[2];

   assign dbg_en  = ctl0_q[31];
   assign dbg_sel = scrub_pkg::ddr_sel_t'(ctl0_q[30:28]);

endmodule

`default_nettype wire

// File: src/ddr_scrubber.sv
// DDR scrubber: walks one channel's address range in fixed bursts and flags completion
`timescale 1ns/1ps
`default_nettype none

`include "scrub_config.svh"

module ddr_scrubber
#(
   parameter scrub_pkg::ddr_addr_t SCRB_MAX_ADDR         = `SCRB_MAX_ADDR,
   parameter int unsigned          SCRB_BURST_LEN_MINUS1 = `SCRB_BURST_LEN_MINUS1
)
(
   input  wire                    clk,
   input  wire                    sync_rst_n,
   input  wire                    scrb_en,
   output scrub_pkg::ddr_addr_t   scrb_addr,
   output logic                   scrb_done
);

   // Bytes covered by one burst
   localparam scrub_pkg::ddr_addr_t BURST_BYTES =
      scrub_pkg::ddr_addr_t'((SCRB_BURST_LEN_MINUS1 + 1) * `SCRB_BEAT_BYTES);

   scrub_pkg::scrub_state_t state_q;
   scrub_pkg::ddr_addr_t    next_addr;

   assign next_addr = scrb_addr + BURST_BYTES;

   // ---------------------------------------------------------------------------
   // Burst walker
   // ---------------------------------------------------------------------------
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state_q   <= scrub_pkg::SCRB_IDLE;
         scrb_addr <= '0;
      end
      else
      begin
         case (state_q)
            scrub_pkg::SCRB_IDLE:
            begin
               scrb_addr <= '0;
               if (scrb_en)
               begin
                  state_q <= scrub_pkg::SCRB_RUN;
               end
            end
            scrub_pkg::SCRB_RUN:
            begin
               if (!scrb_en)
               begin
                  state_q   <= scrub_pkg::SCRB_IDLE;
                  scrb_addr <= '0;
               end
               // Stop on the last burst start, the address holds there
               else if (next_addr > SCRB_MAX_ADDR)
               begin
                  state_q <= scrub_pkg::SCRB_DONE;
               end
               else
               begin
                  scrb_addr <= next_addr;
               end
            end
            scrub_pkg::SCRB_DONE:
            begin
               if (!scrb_en)
               begin
                  state_q   <= scrub_pkg::SCRB_IDLE;
                  scrb_addr <= '0;
               end
            end
            default:
            begin
               state_q   <= scrub_pkg::SCRB_IDLE;
               scrb_addr <= '0;
            end
         endcase
      end
   end

   // Done is a level for as long as the channel stays enabled
   assign scrb_done = (state_q == scrub_pkg::SCRB_DONE);

endmodule

`default_nettype wire

// File: src/scrub_id_readout.sv
// ID readout: registers the fixed PCI ID words or a selected channel's scrub address
`timescale 1ns/1ps
`default_nettype none

`include "scrub_config.svh"

module scrub_id_readout
(
   input  wire                    clk,
   input  wire                    sync_rst_n,
   input  wire                    dbg_en,
   input  scrub_pkg::ddr_sel_t    dbg_sel,
   input  scrub_pkg::ddr_addr_t   addr_a,
   input  scrub_pkg::ddr_addr_t   addr_b,
   input  scrub_pkg::ddr_addr_t   addr_c,
   input  scrub_pkg::ddr_addr_t   addr_d,
   output scrub_pkg::id_word_t    id0,
   output scrub_pkg::id_word_t    id1
);

   scrub_pkg::ddr_addr_t sel_addr;

   // Channel pick, unlisted select codes fall back to A
   always_comb
   begin
      case (dbg_sel)
         scrub_pkg::SEL_DDRB: sel_addr = addr_b;
         scrub_pkg::SEL_DDRD: sel_addr = addr_d;
         scrub_pkg::SEL_DDRC: sel_addr = addr_c;
         default:             sel_addr = addr_a;
      endcase
   end

   // id0 carries the low half, id1 the high half
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= `CL_SH_ID0;
         id1 <= `CL_SH_ID1;
      end
      else if (dbg_en)
      begin
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[63:32];
      end
      else
      begin
         id0 <= `CL_SH_ID0;
         id1 <= `CL_SH_ID1;
      end
   end

endmodule

`default_nettype wire

// File: src/dram_scrub_top.sv
// DRAM scrub control top: reset sync, FLR response, control decode, four scrubbers, ID readout
`timescale 1ns/1ps
`default_nettype none

`include "scrub_config.svh"

module dram_scrub_top
(
   input  wire                    clk,
   input  wire                    rst_main_n,
   input  wire                    flr_assert,
   input  wire  [31:0]            ctl0,
   output logic                   flr_done,
   output logic [`NUM_DDR-1:0]    scrb_done,
   output scrub_pkg::id_word_t    id0,
   output scrub_pkg::id_word_t    id1
);

   // ---------------------------------------------------------------------------
   // Internal signals
   // ---------------------------------------------------------------------------
   logic                    sync_rst_n;
   logic [`NUM_DDR-1:0]     scrb_en;
   logic                    dbg_en;
   scrub_pkg::ddr_sel_t     dbg_sel;

   scrub_pkg::ddr_addr_t    addr_a;
   scrub_pkg::ddr_addr_t    addr_b;
   scrub_pkg::ddr_addr_t    addr_c;
   scrub_pkg::ddr_addr_t    addr_d;
   logic                    done_a;
   logic                    done_b;
   logic                    done_c;
   logic                    done_d;

   // One synchronized reset feeds every block
   reset_sync u_reset_sync
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .sync_rst_n (sync_rst_n)
   );

   flr_responder u_flr
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .flr_assert (flr_assert),
      .flr_done   (flr_done)
   );

   scrub_ctl_regs u_ctl_regs
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .scrb_en    (scrb_en),
      .dbg_en     (dbg_en),
      .dbg_sel    (dbg_sel)
   );

   // ---------------------------------------------------------------------------
   // Channel scrubbers, enables arrive in A,B,C,D order
   // ---------------------------------------------------------------------------
   ddr_scrubber u_scrb_a
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en[0]),
      .scrb_addr  (addr_a),
      .scrb_done  (done_a)
   );

   ddr_scrubber u_scrb_b
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en[1]),
      .scrb_addr  (addr_b),
      .scrb_done  (done_b)
   );

   ddr_scrubber u_scrb_c
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en[2]),
      .scrb_addr  (addr_c),
      .scrb_done  (done_c)
   );

   ddr_scrubber u_scrb_d
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .scrb_en    (scrb_en[3]),
      .scrb_addr  (addr_d),
      .scrb_done  (done_d)
   );

   // Status packs as C,D,B,A to match the control word bit order
   assign scrb_done = {done_c, done_d, done_b, done_a};

   scrub_id_readout u_id_readout
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .dbg_en     (dbg_en),
      .dbg_sel    (dbg_sel),
      .addr_a     (addr_a),
      .addr_b     (addr_b),
      .addr_c     (addr_c),
      .addr_d     (addr_d),
      .id0        (id0),
      .id1        (id1)
   );

endmodule

`default_nettype wire

// File: testbench/tb_dram_scrub_top.sv
// Testbench for the DRAM scrub top covering reset state, scrub completion, readback and FLR
`timescale 1ns/1ps
`default_nettype none

`include "scrub_config.svh"

module tb_dram_scrub_top;

   localparam int unsigned CYCLE_LIMIT     = 2000;
   localparam int unsigned DONE_WAIT_LIMIT = 100;

   // Last burst start of a channel
   localparam scrub_pkg::ddr_addr_t FINAL_ADDR = `SCRB_MAX_ADDR + 64'd1 -
      64'((`SCRB_BURST_LEN_MINUS1 + 1) * `SCRB_BEAT_BYTES);

   logic                clk;
   logic                rst_main_n;
   logic                flr_assert;
   logic [31:0]         ctl0;
   logic                flr_done;
   logic [3:0]          scrb_done;
   scrub_pkg::id_word_t id0;
   scrub_pkg::id_word_t id1;

   integer      seed;
   int unsigned cycles;
   int unsigned error_count;
   int unsigned test_start_errors;
   int unsigned pass_count;
   int unsigned fail_count;

   // Channels the model expects done in ctl0[3:0] bit order
   logic [3:0]  model_done;

   dram_scrub_top DUT
   (
      .clk        (clk),
      .rst_main_n (rst_main_n),
      .flr_assert (flr_assert),
      .ctl0       (ctl0),
      .flr_done   (flr_done),
      .scrb_done  (scrb_done),
      .id0        (id0),
      .id1        (id1)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Run limit
   // ------------------------------------------------------------------------
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("test failed");
         $finish;
      end
   end

   // Expected {id1, id0} from the control word and the model state
   function automatic logic [63:0] expected_ids(input logic [31:0] ctl,
                                                input logic [3:0]  done_mask);
      logic [1:0] chan;
      // Select codes 0..3 line up with enable bits 0..3
      // Codes 4..7 read A
      chan = ctl[30] ? 2'd0 : ctl[29:28];
      if (!ctl[31])
      begin
         return {`CL_SH_ID1, `CL_SH_ID0};
      end
      return done_mask[chan] ? FINAL_ADDR : 64'd0;
   endfunction

   function automatic string chan_name(input int idx);
      case (idx)
         0:       return "A";
         1:       return "B";
         2:       return "D";
         default: return "C";
      endcase
   endfunction

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic apply_ctl(input logic [31:0] value);
      @(negedge clk);
      ctl0 = value;
      // Control register, scrubber and ID register each add one edge
      repeat (4) @(negedge clk);
   endtask

   task automatic check_ids(input string name);
      check(name, expected_ids(ctl0, model_done), {id1, id0});
   endtask

   task automatic wait_done(input logic [3:0] mask, input string name);
      int unsigned n;
      n = 0;
      while (((scrb_done & mask) != mask) && (n < DONE_WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      for (int i = 0; i < 4; i++)
      begin
         if (mask[i] && !scrb_done[i])
         begin
            $display("%s: channel %s never finished its scrub", name, chan_name(i));
            error_count++;
         end
      end
   endtask

   // Counts flr_done pulses seen over a fixed window after a request
   task automatic count_flr_pulses(input int hold, output int pulses);
      pulses = 0;
      @(negedge clk);
      flr_assert = 1'b1;
      for (int k = 0; k < 12; k++)
      begin
         @(negedge clk);
         if (flr_done)
         begin
            pulses++;
         end
         if (k == hold - 1)
         begin
            flr_assert = 1'b0;
         end
      end
   endtask

   task automatic finish_test(input string name);
      if (error_count == test_start_errors)
      begin
         pass_count++;
         $display("%s: ok", name);
      end
      else
      begin
         fail_count++;
         $display("%s: FAILED", name);
      end
      test_start_errors = error_count;
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial
   begin
      logic [31:0] rnd;
      logic [3:0]  mask;
      logic [3:0]  low_bit;
      logic [2:0]  low_sel;
      int          pulses;

      rst_main_n        = 1'b0;
      flr_assert        = 1'b0;
      ctl0              = 32'd0;
      seed              = 9;
      cycles            = 0;
      error_count       = 0;
      test_start_errors = 0;
      pass_count        = 0;
      fail_count        = 0;
      model_done        = 4'd0;

      repeat (3) @(negedge clk);
      rst_main_n = 1'b1;
      repeat (`RST_PIPE_STAGES + 2) @(posedge clk);
      @(negedge clk);

      // Test 1
      check_ids("test 1 ids");
      check("test 1 scrb_done", 64'd0, 64'(scrb_done));
      check("test 1 flr_done", 64'd0, 64'(flr_done));
      finish_test("test 1 reset state");

      // Test 2
      apply_ctl(32'h0000_0001);
      wait_done(4'b0001, "test 2");
      model_done = 4'b0001;
      check("test 2 scrb_done", 64'(model_done), 64'(scrb_done));
      apply_ctl(32'h8000_0001);
      check_ids("test 2 ids");
      finish_test("test 2 channel A scrub");

      // Test 3
      apply_ctl(32'd0);
      model_done = 4'd0;
      rnd = $random(seed);
      mask = rnd[3:0];
      // Force bits 2 and 3 apart so a swap of D and C shows up
      if (mask[3] == mask[2])
      begin
         mask[3] = ~mask[2];
      end
      apply_ctl({1'b1, 3'd0, 24'd0, mask});
      wait_done(mask, "test 3");
      model_done = mask;
      check("test 3 scrb_done", 64'(mask), 64'(scrb_done));
      for (int s = 0; s < 4; s++)
      begin
         apply_ctl({1'b1, 3'(s), 24'd0, mask});
         check_ids($sformatf("test 3 select %0d", s));
      end
      finish_test($sformatf("test 3 random mask %b", mask));

      // Test 4 drops the lowest enabled channel
      low_bit = mask & (~mask + 4'd1);
      low_sel = 3'd0;
      for (int i = 0; i < 4; i++)
      begin
         if (low_bit[i])
         begin
            low_sel = 3'(i);
         end
      end
      model_done = mask & ~low_bit;
      apply_ctl({1'b1, low_sel, 24'd0, model_done});
      check("test 4 scrb_done", 64'(model_done), 64'(scrb_done));
      check_ids("test 4 ids");
      finish_test("test 4 enable cleared");

      // Test 5
      apply_ctl(32'h0000_0001);
      wait_done(4'b0001, "test 5");
      model_done = 4'b0001;
      for (int s = 4; s < 8; s++)
      begin
         apply_ctl({1'b1, 3'(s), 24'd0, 4'b0001});
         check_ids($sformatf("test 5 select %0d", s));
      end
      apply_ctl(32'h0000_0001);
      check_ids("test 5 fixed ids");
      finish_test("test 5 select fallback");

      // Test 6
      count_flr_pulses(1, pulses);
      check("test 6 single request", 64'd1, 64'(pulses));
      repeat (2) @(negedge clk);
      count_flr_pulses(4, pulses);
      check("test 6 held request", 64'd2, 64'(pulses));
      finish_test("test 6 flr response");

      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (fail_count == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
src/scrub_pkg.sv
src/reset_sync.sv
src/flr_responder.sv
src/scrub_ctl_regs.sv
src/ddr_scrubber.sv
src/scrub_id_readout.sv
src/dram_scrub_top.sv
testbench/tb_dram_scrub_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the scrub control testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_dram_scrub_top \
   --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
   cat sim.log
   echo "Simulation exited with an error"
   exit 1
fi

cat sim.log

if grep -q "^test passed$" sim.log; then
   exit 0
else
   exit 1
fi
